//--- Makefile
# Verilator build and run of the pipelined cpu testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_cpu -Mdir obj_dir -f sim.f
	./obj_dir/Vtb_cpu 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/cpu_testdata.hex
// first line holds program length, output count, retired count, branch count, taken count
// then the program words from address 0, then the expected output port words in order
0017 0007 001B 0004 0002
// addresses 0 to 6 adi then dependent add and sub, each written out
4105 F41C 46FD F6C0
FC1C F7C1 FC1C
// addresses 7 to 13 lhi ori not and orr with write-outs
61A5 553C F484 F81C
FBC2 FD03 F01C
// addresses 14 to 17 clear r1, r2 = 3, bne loops back to 16 until r1 == r2
6100 4603 4501 06FE
// addresses 18 to 22 write r1, untaken beq, adi, write r3, hlt
F41C 1401 4710 FC1C
F01D
// expected output port values
0005 0007 FFFE 5AC3
FFFE 0003 0013

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic o_clk,
   output logic o_reset_n
);

   // 100 ns period
   initial begin
      o_clk = 1'b0;
      forever #50 o_clk = ~o_clk;
   end

   // reset low over two rising edges and released just after the second
   initial begin
      o_reset_n = 1'b0;
      repeat (2) @(posedge o_clk);
      #1 o_reset_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- bench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu import cpu_pkg::*; ();

   // testdata header words ahead of the program
   localparam int HDR_WORDS   = 5;
   localparam int MEM_WORDS   = 256;
   // quiet cycles watched after halt
   localparam int TAIL_CYCLES = 10;
   // rom filler past the last program word
   localparam word_t HLT_WORD = {`OPC_RTYPE, 6'd0, `FUNC_HLT};

   logic  clk;
   logic  reset_n;
   word_t i_inst;
   word_t o_i_address;
   word_t o_output_port;
   logic  o_output_valid;
   logic  o_halted;
   word_t o_num_inst;
   word_t o_num_branch;
   word_t o_num_branch_miss;

   word_t testdata [MEM_WORDS];
   int    prog_len;
   int    num_outputs;
   word_t exp_num_inst;
   word_t exp_num_branch;
   word_t exp_num_miss;
   int    out_count   = 0;
   int    cycle_count = 0;
   int    cycle_limit = 0;

   tb_clock u_clock (
      .o_clk     (clk),
      .o_reset_n (reset_n)
   );

   cpu_core UUT (
      .clk               (clk),
      .reset_n           (reset_n),
      .i_inst            (i_inst),
      .o_i_address       (o_i_address),
      .o_output_port     (o_output_port),
      .o_output_valid    (o_output_valid),
      .o_halted          (o_halted),
      .o_num_inst        (o_num_inst),
      .o_num_branch      (o_num_branch),
      .o_num_branch_miss (o_num_branch_miss)
   );

   ////////////////////////////////////////////////////////////
   // failure reporting and compare tasks
   ////////////////////////////////////////////////////////////

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("[ERROR] %s expected %h got %h", name, expected, actual));
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("[ERROR] %s expected %h got %h", name, expected, actual));
      end
   endtask

   // all three performance counters at once
   task automatic check_counters(input word_t inst_cnt, input word_t br_cnt,
                                 input word_t miss_cnt);
      check_word("o_num_inst", inst_cnt, o_num_inst);
      check_word("o_num_branch", br_cnt, o_num_branch);
      check_word("o_num_branch_miss", miss_cnt, o_num_branch_miss);
   endtask

   ////////////////////////////////////////////////////////////
   // instruction rom model
   ////////////////////////////////////////////////////////////

   // program words sit right after the header
   function automatic word_t rom_word(input word_t addr);
      if (int'(addr) < prog_len) begin
         return testdata[HDR_WORDS + int'(addr)];
      end
      return HLT_WORD;
   endfunction

   // expected port values follow the program
   function automatic word_t expected_output(input int idx);
      return testdata[HDR_WORDS + prog_len + idx];
   endfunction

   initial begin
      i_inst = '0;
   end

   // pc only moves at the edge so answer 1 ns later
   always @(posedge clk) begin
      #1;
      i_inst = rom_word(o_i_address);
   end

   // run length guard counted once out of reset
   always @(posedge clk) begin
      if (reset_n) begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("timeout, halt never arrived within %0d cycles",
                                        cycle_limit));
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      $readmemh("bench/cpu_testdata.hex", testdata);
      if ($isunknown(testdata[0]) || $isunknown(testdata[1])) begin
         stop_with_failure("testdata header could not be read");
      end
      prog_len       = int'(testdata[0]);
      num_outputs    = int'(testdata[1]);
      exp_num_inst   = testdata[2];
      exp_num_branch = testdata[3];
      exp_num_miss   = testdata[4];
      if (HDR_WORDS + prog_len + num_outputs > MEM_WORDS) begin
         stop_with_failure("testdata header gives more words than the buffer holds");
      end
      cycle_limit = 8 * prog_len + 20;

      // everything cleared once reset is gone
      @(posedge reset_n);
      @(negedge clk);
      check_flag("o_halted", 1'b0, o_halted);
      check_flag("o_output_valid", 1'b0, o_output_valid);
      check_word("o_output_port", 16'h0000, o_output_port);
      check_counters(16'h0000, 16'h0000, 16'h0000);

      // each strobe must show the next word in order
      while (!o_halted) begin
         @(negedge clk);
         if (o_output_valid && out_count >= num_outputs) begin
            stop_with_failure("output strobe seen after all expected outputs");
         end else if (o_output_valid) begin
            check_word("o_output_port", expected_output(out_count), o_output_port);
            out_count++;
         end
      end

      // final counters with HLT in the retired count
      check_counters(exp_num_inst, exp_num_branch, exp_num_miss);

      // core stays parked
      repeat (TAIL_CYCLES) begin
         @(negedge clk);
         check_flag("o_halted", 1'b1, o_halted);
         check_flag("o_output_valid", 1'b0, o_output_valid);
         check_counters(exp_num_inst, exp_num_branch, exp_num_miss);
      end

      if (out_count == num_outputs) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         stop_with_failure($sformatf("only %0d of %0d expected outputs were seen",
                                     out_count, num_outputs));
      end
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/cpu_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/cpu_core.sv
bench/tb_clock.sv
bench/tb_cpu.sv

//--- src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
   input  wire              clk,
   input  wire              reset_n,
   input  wire word_t       i_inst,
   output word_t            o_i_address,
   output word_t            o_output_port,
   output logic             o_output_valid,
   output logic             o_halted,
   output word_t            o_num_inst,
   output word_t            o_num_branch,
   output word_t            o_num_branch_miss
);

   // forward path bundles
   if_id_t    if_id;
   id_ex_t    id_ex;
   ex_wb_t    ex_wb;
   // backward paths
   wb_fwd_t   wb_fwd;
   redirect_t redirect;

   ////////////////////////////////////////////////////////////
   // four stages
   ////////////////////////////////////////////////////////////

   fetch_stage u_fetch (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_redirect  (redirect),
      .i_inst      (i_inst),
      .o_i_address (o_i_address),
      .o_if_id     (if_id)
   );

   decode_stage u_decode (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_if_id    (if_id),
      .i_redirect (redirect),
      .i_wb_fwd   (wb_fwd),
      .o_id_ex    (id_ex)
   );

   execute_stage u_execute (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_id_ex    (id_ex),
      .i_wb_fwd   (wb_fwd),
      .o_redirect (redirect),
      .o_ex_wb    (ex_wb)
   );

   writeback_stage u_writeback (
      .clk               (clk),
      .reset_n           (reset_n),
      .i_ex_wb           (ex_wb),
      .o_wb_fwd          (wb_fwd),
      .o_output_port     (o_output_port),
      .o_output_valid    (o_output_valid),
      .o_halted          (o_halted),
      .o_num_inst        (o_num_inst),
      .o_num_branch      (o_num_branch),
      .o_num_branch_miss (o_num_branch_miss)
   );

endmodule

`default_nettype wire

//--- src/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// machine word and register file geometry
`define CPU_WORD_W      16
`define CPU_REG_ADDR_W  2
`define CPU_NUM_REGS    4

// major opcodes
`define OPC_BNE         4'd0
`define OPC_BEQ         4'd1
`define OPC_ADI         4'd4
`define OPC_ORI         4'd5
`define OPC_LHI         4'd6
`define OPC_RTYPE       4'd15

// function codes under OPC_RTYPE
`define FUNC_ADD        6'd0
`define FUNC_SUB        6'd1
`define FUNC_AND        6'd2
`define FUNC_ORR        6'd3
`define FUNC_NOT        6'd4
`define FUNC_WWD        6'd28
`define FUNC_HLT        6'd29

// instruction field ranges
`define INST_OPCODE     15:12
`define INST_RS         11:10
`define INST_RT         9:8
`define INST_RD         7:6
`define INST_IMM        7:0
`define INST_FUNC       5:0

`endif

//--- src/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

   // basic vector types
   typedef logic [`CPU_WORD_W-1:0]     word_t;
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [2:0]                 alu_op_t;

   // alu operation codes
   localparam alu_op_t ALU_ADD    = 3'd0;
   localparam alu_op_t ALU_SUB    = 3'd1;
   localparam alu_op_t ALU_AND    = 3'd2;
   localparam alu_op_t ALU_OR     = 3'd3;
   localparam alu_op_t ALU_NOT    = 3'd4;
   localparam alu_op_t ALU_PASS_B = 3'd5;

   ////////////////////////////////////////////////////////////
   // pipeline bundles
   ////////////////////////////////////////////////////////////

   // fetch to decode
   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t inst;
   } if_id_t;

   // decode to execute
   typedef struct packed {
      logic      valid;
      logic      branch;
      logic      branch_eq;
      logic      use_imm;
      logic      reg_write;
      logic      out_write;
      logic      halt;
      alu_op_t   alu_op;
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t dest;
      word_t     op_a;
      word_t     op_b;
      word_t     imm;
      word_t     br_target;
   } id_ex_t;

   // execute to writeback
   typedef struct packed {
      logic      valid;
      logic      reg_write;
      logic      out_write;
      logic      halt;
      logic      is_branch;
      logic      br_taken;
      reg_addr_t dest;
      word_t     result;
      word_t     out_word;
   } ex_wb_t;

   // register write port and forward source
   typedef struct packed {
      logic      we;
      reg_addr_t addr;
      word_t     data;
   } wb_fwd_t;

   // execute back to fetch and decode
   typedef struct packed {
      logic  taken;
      logic  halt;
      word_t target;
   } redirect_t;

endpackage

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decode_stage import cpu_pkg::*; (
   input  wire              clk,
   input  wire              reset_n,
   input  wire if_id_t      i_if_id,
   input  wire redirect_t   i_redirect,
   input  wire wb_fwd_t     i_wb_fwd,
   output id_ex_t           o_id_ex
);

   word_t      inst;
   logic [3:0] opcode;
   logic [5:0] func;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   logic [7:0] imm8;
   word_t      imm_sext;
   word_t      rs_data;
   word_t      rt_data;
   id_ex_t     dec;

   ////////////////////////////////////////////////////////////
   // field split
   ////////////////////////////////////////////////////////////

   assign inst     = i_if_id.inst;
   assign opcode   = inst[`INST_OPCODE];
   assign func     = inst[`INST_FUNC];
   assign rs       = inst[`INST_RS];
   assign rt       = inst[`INST_RT];
   assign rd       = inst[`INST_RD];
   assign imm8     = inst[`INST_IMM];
   assign imm_sext = {{8{imm8[7]}}, imm8};

   // reads bypass the writeback write of the same cycle
   register_file u_regs (
      .clk       (clk),
      .reset_n   (reset_n),
      .i_rs_addr (rs),
      .i_rt_addr (rt),
      .i_wb_fwd  (i_wb_fwd),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   ////////////////////////////////////////////////////////////
   // control decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      dec           = '0;
      dec.valid     = i_if_id.valid;
      dec.rs        = rs;
      dec.rt        = rt;
      dec.dest      = rd;
      dec.op_a      = rs_data;
      dec.op_b      = rt_data;
      dec.imm       = imm_sext;
      dec.alu_op    = ALU_ADD;
      // branch target relative to the next word
      dec.br_target = i_if_id.pc + 1'b1 + imm_sext;
      case (opcode)
         `OPC_BNE: begin
            dec.branch = 1'b1;
         end
         `OPC_BEQ: begin
            dec.branch    = 1'b1;
            dec.branch_eq = 1'b1;
         end
         // i-type results go to rt
         `OPC_ADI: begin
            dec.use_imm   = 1'b1;
            dec.reg_write = 1'b1;
            dec.dest      = rt;
         end
         `OPC_ORI: begin
            dec.use_imm   = 1'b1;
            dec.reg_write = 1'b1;
            dec.dest      = rt;
            dec.alu_op    = ALU_OR;
            dec.imm       = {8'h00, imm8};
         end
         `OPC_LHI: begin
            dec.use_imm   = 1'b1;
            dec.reg_write = 1'b1;
            dec.dest      = rt;
            dec.alu_op    = ALU_PASS_B;
            dec.imm       = {imm8, 8'h00};
         end
         `OPC_RTYPE: begin
            case (func)
               `FUNC_ADD: begin
                  dec.reg_write = 1'b1;
               end
               `FUNC_SUB: begin
                  dec.reg_write = 1'b1;
                  dec.alu_op    = ALU_SUB;
               end
               `FUNC_AND: begin
                  dec.reg_write = 1'b1;
                  dec.alu_op    = ALU_AND;
               end
               `FUNC_ORR: begin
                  dec.reg_write = 1'b1;
                  dec.alu_op    = ALU_OR;
               end
               `FUNC_NOT: begin
                  dec.reg_write = 1'b1;
                  dec.alu_op    = ALU_NOT;
               end
               `FUNC_WWD: dec.out_write = 1'b1;
               `FUNC_HLT: dec.halt      = 1'b1;
               // unknown func becomes a bubble
               default:   dec.valid     = 1'b0;
            endcase
         end
         default: dec.valid = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // id/ex register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      o_id_ex <= dec;
      // squash on taken branch or halt in execute
      if (!reset_n || i_redirect.taken || i_redirect.halt) begin
         o_id_ex.valid     <= 1'b0;
         o_id_ex.branch    <= 1'b0;
         o_id_ex.reg_write <= 1'b0;
         o_id_ex.out_write <= 1'b0;
         o_id_ex.halt      <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
   input  wire              clk,
   input  wire              reset_n,
   input  wire id_ex_t      i_id_ex,
   input  wire wb_fwd_t     i_wb_fwd,
   output redirect_t        o_redirect,
   output ex_wb_t           o_ex_wb
);

   word_t fwd_a;
   word_t fwd_b;
   word_t alu_b;
   word_t alu_result;
   logic  operands_eq;
   logic  br_taken;

   ////////////////////////////////////////////////////////////
   // operand forwarding and alu
   ////////////////////////////////////////////////////////////

   // writeback is the only producer still in flight
   assign fwd_a = (i_wb_fwd.we && i_wb_fwd.addr == i_id_ex.rs) ?
                  i_wb_fwd.data : i_id_ex.op_a;
   assign fwd_b = (i_wb_fwd.we && i_wb_fwd.addr == i_id_ex.rt) ?
                  i_wb_fwd.data : i_id_ex.op_b;

   // immediate or rt as the second operand
   assign alu_b = i_id_ex.use_imm ? i_id_ex.imm : fwd_b;

   always_comb begin
      case (i_id_ex.alu_op)
         ALU_ADD:    alu_result = fwd_a + alu_b;
         ALU_SUB:    alu_result = fwd_a - alu_b;
         ALU_AND:    alu_result = fwd_a & alu_b;
         ALU_OR:     alu_result = fwd_a | alu_b;
         ALU_NOT:    alu_result = ~fwd_a;
         ALU_PASS_B: alu_result = alu_b;
         default:    alu_result = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // branch resolution and halt
   ////////////////////////////////////////////////////////////

   assign operands_eq = (fwd_a == fwd_b);
   // bne on mismatch, beq on match
   assign br_taken    = i_id_ex.valid && i_id_ex.branch &&
                        (i_id_ex.branch_eq ? operands_eq : !operands_eq);

   assign o_redirect = '{taken:  br_taken,
                         halt:   i_id_ex.valid && i_id_ex.halt,
                         target: i_id_ex.br_target};

   ////////////////////////////////////////////////////////////
   // ex/wb register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      o_ex_wb.dest     <= i_id_ex.dest;
      o_ex_wb.result   <= alu_result;
      // wwd emits the forwarded rs
      o_ex_wb.out_word <= fwd_a;
      if (!reset_n) begin
         o_ex_wb.valid     <= 1'b0;
         o_ex_wb.reg_write <= 1'b0;
         o_ex_wb.out_write <= 1'b0;
         o_ex_wb.halt      <= 1'b0;
         o_ex_wb.is_branch <= 1'b0;
         o_ex_wb.br_taken  <= 1'b0;
      end else begin
         // flags qualified by valid here
         o_ex_wb.valid     <= i_id_ex.valid;
         o_ex_wb.reg_write <= i_id_ex.valid && i_id_ex.reg_write;
         o_ex_wb.out_write <= i_id_ex.valid && i_id_ex.out_write;
         o_ex_wb.halt      <= i_id_ex.valid && i_id_ex.halt;
         o_ex_wb.is_branch <= i_id_ex.valid && i_id_ex.branch;
         o_ex_wb.br_taken  <= br_taken;
      end
   end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
   input  wire              clk,
   input  wire              reset_n,
   input  wire redirect_t   i_redirect,
   input  wire word_t       i_inst,
   output word_t            o_i_address,
   output if_id_t           o_if_id
);

   word_t pc;
   // set once HLT reaches execute
   logic  frozen;

   // rom is addressed straight from pc
   assign o_i_address = pc;

   always_ff @(posedge clk) begin
      // rom word and its address
      o_if_id.pc   <= pc;
      o_if_id.inst <= i_inst;
      if (!reset_n) begin
         pc            <= '0;
         frozen        <= 1'b0;
         o_if_id.valid <= 1'b0;
      end else if (frozen || i_redirect.halt) begin
         // pc holds and only bubbles follow
         frozen        <= 1'b1;
         o_if_id.valid <= 1'b0;
      end else if (i_redirect.taken) begin
         // word fetched this cycle is in the branch shadow
         pc            <= i_redirect.target;
         o_if_id.valid <= 1'b0;
      end else begin
         // always-untaken so just step
         pc            <= pc + 1'b1;
         o_if_id.valid <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module register_file import cpu_pkg::*; (
   input  wire              clk,
   input  wire              reset_n,
   input  wire reg_addr_t   i_rs_addr,
   input  wire reg_addr_t   i_rt_addr,
   input  wire wb_fwd_t     i_wb_fwd,
   output word_t            o_rs_data,
   output word_t            o_rt_data
);

   word_t regs [`CPU_NUM_REGS];

   // write at the clock edge and clear all on reset
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb_fwd.we) begin
         regs[i_wb_fwd.addr] <= i_wb_fwd.data;
      end
   end

   // write-through when reading the register being written
   assign o_rs_data = (i_wb_fwd.we && i_wb_fwd.addr == i_rs_addr) ?
                      i_wb_fwd.data : regs[i_rs_addr];
   assign o_rt_data = (i_wb_fwd.we && i_wb_fwd.addr == i_rt_addr) ?
                      i_wb_fwd.data : regs[i_rt_addr];

endmodule

`default_nettype wire

//--- src/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import cpu_pkg::*; (
   input  wire              clk,
   input  wire              reset_n,
   input  wire ex_wb_t      i_ex_wb,
   output wb_fwd_t          o_wb_fwd,
   output word_t            o_output_port,
   output logic             o_output_valid,
   output logic             o_halted,
   output word_t            o_num_inst,
   output word_t            o_num_branch,
   output word_t            o_num_branch_miss
);

   // write port that execute also sees as its forward source
   assign o_wb_fwd = '{we:   i_ex_wb.reg_write,
                       addr: i_ex_wb.dest,
                       data: i_ex_wb.result};

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_output_port     <= '0;
         o_output_valid    <= 1'b0;
         o_halted          <= 1'b0;
         o_num_inst        <= '0;
         o_num_branch      <= '0;
         o_num_branch_miss <= '0;
      end else begin
         // one-cycle strobe per retired wwd
         o_output_valid <= i_ex_wb.out_write;
         if (i_ex_wb.out_write) begin
            o_output_port <= i_ex_wb.out_word;
         end
         // sticky halt level
         if (i_ex_wb.halt) begin
            o_halted <= 1'b1;
         end
         // retired count includes the hlt itself
         if (i_ex_wb.valid) begin
            o_num_inst <= o_num_inst + 1'b1;
         end
         if (i_ex_wb.is_branch) begin
            o_num_branch <= o_num_branch + 1'b1;
         end
         // predicted untaken so every taken branch missed
         if (i_ex_wb.br_taken) begin
            o_num_branch_miss <= o_num_branch_miss + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
